/* sim.f */
+incdir+logic
logic/sbusPkg.sv
logic/memCorePkg.sv
logic/memBusIf.sv
logic/cycleControl.sv
logic/quadWordCounter.sv
logic/coreArray.sv
logic/sbusMemory.sv
testbench/sbusMemoryChecks.sv
testbench/sbusMemoryTb.sv

/* Makefile */
# Verilator build and run of the SBUS core memory bank testbench

VERILATOR ?= verilator
TOP       ?= sbusMemoryTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/sbusMemoryTb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the SBUS core memory bank: clock, reset and LFSR bursts
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "mem_defs.svh"

module sbusMemoryTb;
  timeunit 1ns;
  timeprecision 100ps;
  import sbusPkg::*;

  localparam logic [31:0] seedValue = 32'd90520;
  localparam int          waitLimit = 16;     // Cycles one drain may take
  localparam int          runLimit  = 2000;   // Cycles for the whole run

  logic        SBUS;
  logic        arstN;
  logic        start;
  sbusAdrT     adr;
  rqMaskT      rq;
  logic        wrRq;
  word36T      dIn;
  logic        parIn;
  logic        ackn;
  logic        dataValid;
  word36T      dOut;
  logic        dataPar;
  logic        parErr;
  logic        checkFailed;
  logic [31:0] lfsr;          // Galois LFSR state
  sbusAdrT     written [$];   // Full quadword writes, read back later

  sbusMemory uut (
    .SBUS(SBUS), .arstN(arstN), .start(start), .adr(adr), .rq(rq), .wrRq(wrRq),
    .dIn(dIn), .parIn(parIn), .ackn(ackn), .dataValid(dataValid), .dOut(dOut),
    .dataPar(dataPar), .parErr(parErr)
  );

  sbusMemoryChecks uChecks (
    .SBUS(SBUS), .arstN(arstN), .start(start), .adr(adr), .rq(rq), .wrRq(wrRq),
    .dIn(dIn), .parIn(parIn), .ackn(ackn), .dataValid(dataValid), .dOut(dOut),
    .dataPar(dataPar), .parErr(parErr), .failed(checkFailed)
  );

  initial begin
    SBUS = 1'b0;
    forever #2 SBUS = ~SBUS;   // 4 ns period
  end

  task automatic abortRun(input string why);
    $display("ERROR: %s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  // Checker flags settle at the rising edge, act half a cycle later
  always @(negedge SBUS) begin
    if (checkFailed) abortRun("port checker reported a mismatch");
  end

  initial begin
    repeat (runLimit) @(posedge SBUS);
    abortRun("run did not finish within its cycle limit");
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic randomBits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = galoisStep(lfsr);
      v    = {v[62:0], lfsr[0]};   // One step per bit
    end
  endtask

  task automatic randomAdr(output sbusAdrT a);
    logic [63:0] r;
    randomBits(`SBUS_ADR_BITS, r);
    a = r[`SBUS_ADR_BITS-1:0];
  endtask

  task automatic randomMask(output rqMaskT m);
    logic [63:0] r;
    randomBits(4, r);
    m = r[3:0];
  endtask

  task automatic nextCycle();
    @(posedge SBUS);
    #0.5;
  endtask

  // Start pulse, returns in slot 0
  task automatic startBurst(input sbusAdrT a, input rqMaskT m, input logic wr);
    start = 1'b1;
    adr   = a;
    rq    = m;
    wrRq  = wr;
    nextCycle();
    start = 1'b0;
  endtask

  // Write data per slot, returns inside slot 3 so a next start can chain
  task automatic driveSlots(input logic wr, input logic badPar);
    logic [63:0] r;
    for (int i = 0; i < 4; i++) begin
      if (wr) begin
        randomBits(`WORD_BITS, r);
        dIn   = r[`WORD_BITS-1:0];
        parIn = (^dIn) ^ badPar;   // Flip to force a parity error
      end else begin
        dIn   = '0;
        parIn = 1'b0;
      end
      if (i < 3) nextCycle();
    end
  endtask

  task automatic endBurst();
    nextCycle();
    dIn   = '0;
    parIn = 1'b0;
  endtask

  task automatic burst(input sbusAdrT a, input rqMaskT m, input logic wr, input logic badPar);
    startBurst(a, m, wr);
    driveSlots(wr, badPar);
    endBurst();
  endtask

  task automatic waitQuiet();
    int n;
    n = 0;
    while ((ackn || parErr) && n < waitLimit) begin
      nextCycle();
      n++;
    end
    if (ackn || parErr) abortRun("bank still acknowledging after its timeout");
  endtask

  initial begin
    sbusAdrT     a;
    sbusAdrT     b;
    rqMaskT      m;
    logic [63:0] r;
    arstN = 1'b0;
    start = 1'b0;
    adr   = '0;
    rq    = '0;
    wrRq  = 1'b0;
    dIn   = '0;
    parIn = 1'b0;
    lfsr  = seedValue;
    repeat (2) @(posedge SBUS);
    #0.5;
    arstN = 1'b1;
    repeat (3) nextCycle();   // Quiet bus before any start

    // Full writes at random addresses, then read them all back
    for (int n = 0; n < 8; n++) begin
      randomAdr(a);
      burst(a, 4'hF, 1'b1, 1'b0);
      written.push_back(a);
    end
    foreach (written[i]) begin
      burst(written[i], 4'hF, 1'b0, 1'b0);
    end

    // Random masks, read back from another offset in the same quadword
    for (int n = 0; n < 8; n++) begin
      randomAdr(a);
      randomMask(m);
      burst(a, m, 1'b1, 1'b0);
      randomBits(2, r);
      randomMask(m);
      burst({a[`SBUS_ADR_BITS-1:2], r[1:0]}, m, 1'b0, 1'b0);
    end

    randomAdr(a);
    burst(a, 4'hF, 1'b1, 1'b1);   // Bad parity still stores the word
    burst(a, 4'hF, 1'b0, 1'b0);
    waitQuiet();

    // Chain starts in the last slot, one burst with an empty mask
    randomAdr(a);
    randomAdr(b);
    startBurst(a, 4'hF, 1'b1);
    driveSlots(1'b1, 1'b0);
    startBurst(a, 4'hF, 1'b0);
    driveSlots(1'b0, 1'b0);
    startBurst(b, 4'h0, 1'b0);
    driveSlots(1'b0, 1'b0);
    randomMask(m);
    startBurst(a, m, 1'b0);
    driveSlots(1'b0, 1'b0);
    endBurst();
    burst(b, 4'h0, 1'b1, 1'b0);   // Silent write slots
    burst(a, 4'hF, 1'b0, 1'b0);

    // Upper address bits differ, same core word
    randomAdr(a);
    randomBits(`SBUS_ADR_BITS - `MEM_ADR_BITS, r);
    b = a;
    b[`SBUS_ADR_BITS-1:`MEM_ADR_BITS] = a[`SBUS_ADR_BITS-1:`MEM_ADR_BITS] ^
                                        {r[`SBUS_ADR_BITS-`MEM_ADR_BITS-1:1], 1'b1};
    burst(a, 4'hF, 1'b1, 1'b0);
    burst(b, 4'hF, 1'b0, 1'b0);
    burst(b, 4'hF, 1'b1, 1'b0);
    burst(a, 4'hF, 1'b0, 1'b0);

    waitQuiet();
    repeat (2) nextCycle();
    if (checkFailed) begin
      abortRun("port checker reported a mismatch");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* testbench/sbusMemoryChecks.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the bank and port assertions for the SBUS testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "mem_defs.svh"

module sbusMemoryChecks (
  input  wire logic             SBUS,
  input  wire logic             arstN,
  input  wire logic             start,
  input  wire sbusPkg::sbusAdrT adr,
  input  wire sbusPkg::rqMaskT  rq,
  input  wire logic             wrRq,
  input  wire sbusPkg::word36T  dIn,
  input  wire logic             parIn,
  input  wire logic             ackn,
  input  wire logic             dataValid,
  input  wire sbusPkg::word36T  dOut,
  input  wire logic             dataPar,
  input  wire logic             parErr,
  output logic                  failed      // Sticky flag set by any mismatch
);
  timeunit 1ns;
  timeprecision 100ps;
  import sbusPkg::*;

  logic [2:0]            remQ;     // Slots left in burst including the current one
  logic [1:0]            offQ;     // Word offset of current slot
  rqMaskT                maskQ;    // Head bit belongs to current slot
  memAdrT                baseQ;
  logic                  wrQ;
  logic                  parErrQ;  // Expected parity flag
  word36T                shadow [`MEM_WORDS];
  logic [`MEM_WORDS-1:0] known;    // Words written since reset

  logic   accept;
  logic   expAck;
  logic   expKnown;
  memAdrT expAdr;
  word36T expWord;
  logic   ackOk;
  logic   validOk;
  logic   dataOk;
  logic   parOk;
  logic   quietOk;
  logic   parErrOk;

  assign accept   = start && (remQ <= 3'd1);   // Idle or last slot
  assign expAck   = (remQ != 3'd0) && maskQ[3];
  assign expAdr   = {baseQ[`MEM_ADR_BITS-1:2], offQ};   // Upper bus bits alias away
  assign expWord  = shadow[expAdr];
  assign expKnown = known[expAdr];

  // Slot schedule of four slots per accepted start
  always_ff @(posedge SBUS or negedge arstN) begin
    if (!arstN) begin
      remQ    <= '0;
      offQ    <= '0;
      maskQ   <= '0;
      baseQ   <= '0;
      wrQ     <= 1'b0;
      parErrQ <= 1'b0;
    end else begin
      parErrQ <= expAck && wrQ && ((^dIn) != parIn);   // Even parity on the word
      if (accept) begin
        remQ  <= 3'd4;
        offQ  <= adr[1:0];
        maskQ <= rq;
        baseQ <= adr[`MEM_ADR_BITS-1:0];
        wrQ   <= wrRq;
      end else if (remQ != 3'd0) begin
        remQ  <= remQ - 3'd1;
        offQ  <= offQ + 2'd1;           // Wraps inside the quadword
        maskQ <= {maskQ[2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge SBUS or negedge arstN) begin
    if (!arstN) begin
      known <= '0;
    end else if (expAck && wrQ) begin
      known[expAdr] <= 1'b1;
    end
  end

  // Shadow copy of the core
  always_ff @(posedge SBUS) begin
    if (expAck && wrQ) begin
      shadow[expAdr] <= dIn;
    end
  end

  assign ackOk    = ackn == expAck;
  assign validOk  = dataValid == expAck;
  assign dataOk   = !(expAck && !wrQ && expKnown) || (dOut == expWord);
  assign parOk    = !(expAck && !wrQ && expKnown) || (dataPar == ^expWord);
  assign quietOk  = expAck || ((dOut == '0) && !dataPar);
  assign parErrOk = parErr == parErrQ;

  always_ff @(posedge SBUS or negedge arstN) begin
    if (!arstN) begin
      failed <= 1'b0;
    end else if (!(ackOk && validOk && dataOk && parOk && quietOk && parErrOk)) begin
      failed <= 1'b1;
    end
  end

  acknTiming: assert property (@(posedge SBUS) disable iff (!arstN) ackOk)
    else $display("FAIL acknTiming: expected %b actual %b", $sampled(expAck), $sampled(ackn));

  validTiming: assert property (@(posedge SBUS) disable iff (!arstN) validOk)
    else $display("FAIL validTiming: expected %b actual %b",
                  $sampled(expAck), $sampled(dataValid));

  // Read data comes from the shadow and only for words already written
  readData: assert property (@(posedge SBUS) disable iff (!arstN) dataOk)
    else $display("FAIL readData: expected %h actual %h", $sampled(expWord), $sampled(dOut));

  // Parity of the shadow word
  readParity: assert property (@(posedge SBUS) disable iff (!arstN) parOk)
    else $display("FAIL readParity: expected %b actual %b",
                  $sampled(^expWord), $sampled(dataPar));

  quietBus: assert property (@(posedge SBUS) disable iff (!arstN) quietOk)
    else $display("FAIL quietBus: expected %h actual %h", '0, $sampled(dOut));

  parErrPulse: assert property (@(posedge SBUS) disable iff (!arstN) parErrOk)
    else $display("FAIL parErrPulse: expected %b actual %b",
                  $sampled(parErrQ), $sampled(parErr));

endmodule

`default_nettype wire

/* logic/sbusMemory.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One SBUS phase of a core memory bank with split data in and out
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module sbusMemory (
  input  wire logic             SBUS,
  input  wire logic             arstN,
  input  wire logic             start,       // One cycle request pulse
  input  wire sbusPkg::sbusAdrT adr,
  input  wire sbusPkg::rqMaskT  rq,
  input  wire logic             wrRq,
  input  wire sbusPkg::word36T  dIn,
  input  wire logic             parIn,
  output logic                  ackn,
  output logic                  dataValid,
  output sbusPkg::word36T       dOut,
  output logic                  dataPar,
  output logic                  parErr
);

  memBusIf bus ();

  logic slotAck;   // Requested slot in progress

  cycleControl uCtrl (
    .SBUS  (SBUS),
    .arstN (arstN),
    .start (start),
    .adr   (adr),
    .rq    (rq),
    .wrRq  (wrRq),
    .bus   (bus.ctrl)
  );

  quadWordCounter uCount (
    .SBUS  (SBUS),
    .arstN (arstN),
    .bus   (bus.count)
  );

  coreArray uArray (
    .SBUS    (SBUS),
    .arstN   (arstN),
    .bus     (bus.array),
    .dIn     (dIn),
    .parIn   (parIn),
    .dOut    (dOut),
    .dataPar (dataPar),
    .parErr  (parErr)
  );

  // Acknowledge and valid move together in this bank
  assign slotAck   = bus.slotAck;
  assign ackn      = slotAck;
  assign dataValid = slotAck;

endmodule

`default_nettype wire

/* logic/coreArray.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core storage: read data with parity, writes and write parity check
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "mem_defs.svh"

module coreArray (
  input  wire logic            SBUS,
  input  wire logic            arstN,
  memBusIf.array               bus,
  input  wire sbusPkg::word36T dIn,
  input  wire logic            parIn,
  output sbusPkg::word36T      dOut,
  output logic                 dataPar,
  output logic                 parErr
);
  import sbusPkg::*;

  word36T mem [`MEM_WORDS];   // The core itself
  memAdrT wordAdr;
  logic   wrSlot;             // Acknowledged write slot
  logic   rdSlot;             // Acknowledged read slot

  // Quadword from the captured address and word from the counter
  assign wordAdr = {bus.quadBase[`MEM_ADR_BITS-1:2], bus.curOff};

  assign wrSlot = bus.slotAck && bus.writeCycle;
  assign rdSlot = bus.slotAck && !bus.writeCycle;

  // Zero latency read and the bus idles at zero
  assign dOut    = rdSlot ? mem[wordAdr] : '0;
  assign dataPar = ^dOut;     // XOR of the word

  // Word lands at the edge closing its slot
  always_ff @(posedge SBUS) begin
    if (wrSlot) begin
      mem[wordAdr] <= dIn;
    end
  end

  // One cycle flag after a write with bad parity
  always_ff @(posedge SBUS or negedge arstN) begin
    if (!arstN) begin
      parErr <= 1'b0;
    end else begin
      parErr <= wrSlot && ((^dIn) != parIn);
    end
  end

  // Data lines only carry a word in an acknowledged read slot
  quietBus: assert property (@(posedge SBUS) disable iff (!arstN)
    !bus.slotAck |-> (dOut == '0) && !dataPar)
    else $error("coreArray: data driven outside an acknowledged slot");

endmodule

`default_nettype wire

/* logic/quadWordCounter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot counter for one burst: word offset mod 4 and remaining request mask
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module quadWordCounter (
  input wire logic SBUS,
  input wire logic arstN,
  memBusIf.count   bus
);
  import sbusPkg::*;
  import memCorePkg::*;

  wordOffT    offQ;    // Offset for the slot after this one
  rqMaskT     maskQ;   // Mask still to serve, head is next slot
  logic [2:0] cntQ;    // Slots still to run
  rqMaskT     mask;    // Mask seen by the current slot
  logic [2:0] cnt;

  // Slot 0 works straight from the captured request
  always_comb begin
    if (bus.load) begin
      bus.curOff = bus.startOff;
      mask       = bus.rqIn;
      cnt        = 3'd4;          // A burst always has four slots
    end else begin
      bus.curOff = offQ;
      mask       = maskQ;
      cnt        = cntQ;
    end
  end

  assign bus.slotAck   = mask[3] && (cnt != 3'd0);
  assign bus.slotsLeft = cnt > 3'd1;

  always_ff @(posedge SBUS or negedge arstN) begin
    if (!arstN) begin
      offQ  <= '0;
      maskQ <= '0;
      cntQ  <= 3'd0;
    end else if (cnt != 3'd0) begin
      offQ  <= bus.curOff + 2'd1;   // Wraps inside the quadword
      maskQ <= mask << 1;
      cntQ  <= cnt - 3'd1;
    end
  end

  // Offset steps by one from slot to slot of a burst
  offsetStep: assert property (@(posedge SBUS) disable iff (!arstN)
    bus.slotsLeft |=> bus.curOff == wordOffT'($past(bus.curOff) + 2'd1))
    else $error("quadWordCounter: word offset skipped");

endmodule

`default_nettype wire

/* logic/cycleControl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst FSM: takes start in idle or in the last slot, captures the request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cycleControl (
  input  wire logic             SBUS,
  input  wire logic             arstN,
  input  wire logic             start,
  input  wire sbusPkg::sbusAdrT adr,
  input  wire sbusPkg::rqMaskT  rq,
  input  wire logic             wrRq,
  memBusIf.ctrl                 bus
);
  import sbusPkg::*;
  import memCorePkg::*;

  cycleStateT stateQ;   // Registered state holds only idle or burst
  cycleStateT state;    // Decoded state adds lastSlot
  logic       accept;   // Start taken at this edge

  // Slot 3 is known only once the counter drops slotsLeft
  always_comb begin
    state = stateQ;
    if (stateQ == burst && !bus.slotsLeft) begin
      state = lastSlot;
    end
  end

  assign accept = start && (state != burst);  // Idle or last slot

  always_ff @(posedge SBUS or negedge arstN) begin
    if (!arstN) begin
      stateQ   <= idle;
      bus.load <= 1'b0;
    end else begin
      bus.load <= accept;             // Marks slot 0 for the counter
      case (state)
        idle: begin
          if (accept) stateQ <= burst;
        end
        burst: begin
          stateQ <= burst;            // Counter decides when slot 3 comes
        end
        lastSlot: begin
          stateQ <= accept ? burst : idle;   // Back to back with no gap
        end
        default: begin
          stateQ <= idle;
        end
      endcase
    end
  end

  // Request capture
  always_ff @(posedge SBUS) begin
    if (accept) begin
      bus.quadBase   <= memAdrT'(adr);   // Upper address bits alias
      bus.startOff   <= wordOffT'(adr);
      bus.rqIn       <= rq;
      bus.writeCycle <= wrRq;
    end
  end

  // Requester must wait for the last slot before the next start
  startInBurst: assert property (@(posedge SBUS) disable iff (!arstN)
    !(start && state == burst))
    else $error("cycleControl: start during burst slots ignored");

  // A burst begins only where a start met no pending slots in the counter
  loadFromStart: assert property (@(posedge SBUS) disable iff (!arstN)
    bus.load |-> $past(start && !bus.slotsLeft))
    else $error("cycleControl: load without an accepted start");

endmodule

`default_nettype wire

/* logic/memBusIf.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst steering between cycle control, slot counter and core array
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface memBusIf;
  import sbusPkg::*;
  import memCorePkg::*;

  logic    load;        // High during slot 0 of a burst
  memAdrT  quadBase;    // Captured address
  wordOffT startOff;    // Captured word offset
  logic    writeCycle;
  rqMaskT  rqIn;        // Captured request mask
  logic    slotAck;     // Current slot is requested
  wordOffT curOff;      // Word offset of current slot
  logic    slotsLeft;   // More slots follow the current one

  // Sequencer, watches the counter to find the last slot
  modport ctrl (output load, quadBase, startOff, writeCycle, rqIn,
                input  slotsLeft);

  modport count (input  load, startOff, rqIn,
                 output slotAck, curOff, slotsLeft);

  // Data side only needs where and whether
  modport array (input quadBase, curOff, slotAck, writeCycle);

endinterface

`default_nettype wire

/* logic/memCorePkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types private to the bank: burst cycle states and word offset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package memCorePkg;

  typedef logic [1:0] wordOffT;  // Offset within a quadword, wraps mod 4

  // Burst sequencing
  typedef enum logic [1:0] {
    idle     = 2'd0,  // No burst running
    burst    = 2'd1,  // Slots 0..2
    lastSlot = 2'd2   // Slot 3, a new start may be taken here
  } cycleStateT;

endpackage

`default_nettype wire

/* logic/sbusPkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SBUS vector types seen at the bank ports and by the data path
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "mem_defs.svh"

package sbusPkg;

  // One data word as it travels on the bus
  typedef logic [`WORD_BITS-1:0] word36T;

  typedef logic [`SBUS_ADR_BITS-1:0] sbusAdrT;  // Word address, [1:0] is quadword offset

  // One bit per quadword slot
  // MSB belongs to the slot at the starting offset
  typedef logic [3:0] rqMaskT;

  typedef logic [`MEM_ADR_BITS-1:0] memAdrT;  // Address after dropping aliased bits

endpackage

`default_nettype wire

/* logic/mem_defs.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core memory bank sizes: bus word, bus address and bank depth
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Bus side
`define WORD_BITS     36      // Data word incl. no parity
`define SBUS_ADR_BITS 22      // Word address, low two bits pick the quadword slot

// Bank side
`define MEM_ADR_BITS  12      // Bits the bank decodes, the rest alias
`define MEM_WORDS     4096    // Must equal 2**MEM_ADR_BITS

`endif
